// File: tb.f
hw/routerPkg.sv
hw/portTimer.sv
hw/outputArbiter.sv
hw/flitMux.sv
hw/routerOutput.sv
tests/routerOutput_asserts.sv
tests/tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide on the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb -f tb.f -o simv \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -qx "TEST PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tests/tb.sv
`timescale 1ns/10ps

module tb
  import routerPkg::*;
();

  localparam int flitWidth  = 16;
  localparam int cycleLimit = 3000; // roughly twice the summed test length

  localparam portVec priorityCases [6] = '{
    5'b11111, 5'b11110, 5'b11100, 5'b11000, 5'b10000, 5'b01010
  };

  logic                 clk;
  logic                 rst;
  portVec               req;
  portVec               flitValid;
  logic [flitWidth-1:0] flits [numPorts];
  portVec               grant;
  logic [flitWidth-1:0] outFlit;
  logic                 outValid;

  // reference model
  int                   modelHolder; // -1 when idle
  pktLength             modelCount [numPorts];
  pktLength             modelLen [numPorts];
  logic                 modelValid;
  logic [flitWidth-1:0] modelFlit;

  int    seed;
  int    cycles = 0;
  int    errors = 0;
  int    errorsAtStart;
  int    passCount = 0;
  int    failCount = 0;
  string testName;

  routerOutput #(.flitWidth(flitWidth)) i_routerOutput (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitValid(flitValid),
    .flitL    (flits[portIdxL]),
    .flitN    (flits[portIdxN]),
    .flitE    (flits[portIdxE]),
    .flitW    (flits[portIdxW]),
    .flitS    (flits[portIdxS]),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycleLimit)
    begin
      $display("run timed out after %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ##############################
  // helpers
  // ##############################

  function automatic logic [31:0] randomWord();
    return $random(seed);
  endfunction

  function automatic logic [flitWidth-1:0] headFlit(pktLength len);
    logic [flitWidth-1:0] f;
    f = '0;
    f[flitWidth-1 -: 3] = flitIdHead;
    f[11:0] = len;
    return f;
  endfunction

  function automatic logic [flitWidth-1:0] bodyFlit(logic [31:0] bits);
    logic [flitWidth-1:0] f;
    f = bits[flitWidth-1:0];
    if (f[flitWidth-1 -: 3] == flitIdHead)
      f[flitWidth-1 -: 3] = 3'b010; // never a head
    return f;
  endfunction

  // search in rotation order, -1 if nobody asks
  function automatic int firstRequester(portVec r, int from, int span);
    int idx;
    for (int k = 0; k < span; k++)
    begin
      idx = (from + k) % numPorts;
      if (r[idx])
        return idx;
    end
    return -1;
  endfunction

  // one clock edge of the model, inputs still as sampled
  task automatic modelStep();
    logic stay;
    int   nextHolder;
    stay = 1'b0;
    if (rst)
    begin
      modelHolder = -1;
      modelValid  = 1'b0;
      for (int q = 0; q < numPorts; q++)
      begin
        modelCount[q] = '0;
        modelLen[q]   = '0;
      end
    end
    else
    begin
      if (modelHolder >= 0)
        stay = req[modelHolder] && (modelCount[modelHolder] != modelLen[modelHolder]);
      modelValid = (modelHolder >= 0) && flitValid[modelHolder];
      if (modelValid)
        modelFlit = flits[modelHolder];
      for (int q = 0; q < numPorts; q++)
      begin
        if (stay && (q == modelHolder))
          modelCount[q] = modelCount[q] + 12'd1;
        else
          modelCount[q] = '0;
        if (flitValid[q] && (flits[q][flitWidth-1 -: 3] == flitIdHead))
          modelLen[q] = flits[q][11:0]; // any head flit, granted or not
      end
      if (modelHolder < 0)
        nextHolder = firstRequester(req, 0, numPorts);
      else if (stay)
        nextHolder = modelHolder;
      else
        nextHolder = firstRequester(req, modelHolder + 1, numPorts - 1);
      modelHolder = nextHolder;
    end
  endtask

  task automatic checkOutputs();
    portVec expGrant;
    expGrant = '0;
    if (modelHolder >= 0)
      expGrant[modelHolder] = 1'b1;
    assert (grant === expGrant)
    else
    begin
      $display("ERROR %s: grant expected %b, actual %b", testName, expGrant, grant);
      errors++;
    end
    assert (outValid === modelValid)
    else
    begin
      $display("ERROR %s: outValid expected %b, actual %b", testName, modelValid, outValid);
      errors++;
    end
    if (modelValid)
      assert (outFlit === modelFlit)
      else
      begin
        $display("ERROR %s: outFlit expected %h, actual %h", testName, modelFlit, outFlit);
        errors++;
      end
  endtask

  task automatic nextCycle();
    @(negedge clk);
    modelStep();
    checkOutputs();
  endtask

  task automatic startTest(string name);
    testName      = name;
    errorsAtStart = errors;
  endtask

  task automatic endTest();
    if (errors == errorsAtStart)
    begin
      passCount++;
      $display("test %s: passed", testName);
    end
    else
    begin
      failCount++;
      $display("test %s: failed with %0d errors", testName, errors - errorsAtStart);
    end
  endtask

  // ##############################
  // tests
  // ##############################

  initial
  begin
    logic [31:0] word;
    logic [31:0] fw;
    seed      = 32'h6c45_0078;
    rst       = 1'b1;
    req       = '0;
    flitValid = '0;
    for (int q = 0; q < numPorts; q++)
      flits[q] = '0;

    startTest("reset and idle");
    repeat (4) nextCycle();
    rst = 1'b0;
    repeat (6) nextCycle();
    endTest();

    startTest("fixed priority");
    for (int i = 0; i < 6; i++)
    begin
      req = priorityCases[i];
      repeat (2) nextCycle();
      req = '0;
      repeat (2) nextCycle();
    end
    endTest();

    startTest("timed hold");
    req = 5'b00010;
    flitValid = 5'b00010;
    flits[portIdxN] = headFlit(12'd3);
    nextCycle();
    flitValid = '0;
    repeat (14) nextCycle(); // hold, idle gap, hold again
    req = 5'b00100;          // E never saw a head flit
    repeat (6) nextCycle();
    req = '0;
    repeat (2) nextCycle();
    endTest();

    startTest("round-robin rotation");
    flits[portIdxL] = headFlit(12'd1);
    flits[portIdxN] = headFlit(12'd2);
    flits[portIdxE] = headFlit(12'd0);
    flits[portIdxW] = headFlit(12'd1);
    flits[portIdxS] = headFlit(12'd2);
    flitValid = '1;
    nextCycle();
    flitValid = '0;
    req = '1;
    repeat (40) nextCycle();
    req = '0;
    repeat (2) nextCycle();
    endTest();

    startTest("request drop and forwarding");
    flits[portIdxL] = headFlit(12'd6);
    flitValid = 5'b00001;
    nextCycle();
    req = 5'b00101;
    for (int i = 0; i < 12; i++)
    begin
      for (int q = 0; q < numPorts; q++)
        flits[q] = bodyFlit(randomWord());
      flitValid = '1; // ungranted strobes must be dropped
      if (i == 3)
        req[portIdxL] = 1'b0; // mid-hold
      nextCycle();
    end
    req = '0;
    flitValid = '0;
    repeat (2) nextCycle();
    endTest();

    startTest("random traffic");
    for (int i = 0; i < 1500; i++)
    begin
      word = randomWord();
      if (word[10:8] == 3'd0)
        req = word[4:0]; // requests stay put for a while
      flitValid = word[15:11];
      for (int q = 0; q < numPorts; q++)
      begin
        fw = randomWord();
        if (fw[3:0] == 4'd0)
          flits[q] = headFlit({9'd0, fw[6:4]});
        else
          flits[q] = bodyFlit(fw);
      end
      nextCycle();
    end
    req = '0;
    flitValid = '0;
    repeat (3) nextCycle();
    endTest();

    $display("tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount, errors);
    if ((failCount == 0) && (errors == 0))
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tests/routerOutput_asserts.sv
`timescale 1ns/10ps

module routerOutputAsserts
  import routerPkg::*;
(
  input logic   clk,
  input logic   rst,
  input portVec req,
  input portVec grant,
  input logic   outValid
);

  logic [12:0] holdCycles; // cycles the current grant has lasted
  portVec      lastGrant;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdCycles <= '0;
      lastGrant  <= '0;
    end
    else
    begin
      lastGrant <= grant;
      if (grant == '0)
        holdCycles <= '0;
      else if (grant == lastGrant)
        holdCycles <= holdCycles + 13'd1;
      else
        holdCycles <= 13'd1;
    end
  end

  // ##############################
  // grant and output rules
  // ##############################

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set");

  grantFollowsReq: assert property (@(posedge clk) disable iff (rst)
    (grant & ~$past(req)) == '0)
    else $error("grant given to a port that was not requesting");

  validFollowsGrant: assert property (@(posedge clk) disable iff (rst)
    outValid |-> ($past(grant) != '0))
    else $error("output strobe without a grant in the cycle before");

  holdBounded: assert property (@(posedge clk) disable iff (rst) holdCycles <= 13'd4096)
    else $error("grant held longer than the largest hold length");

endmodule

bind routerOutput routerOutputAsserts checks (
  .clk     (clk),
  .rst     (rst),
  .req     (req),
  .grant   (grant),
  .outValid(outValid)
);

// File: hw/routerOutput.sv
`timescale 1ns/10ps

module routerOutput
  import routerPkg::*;
#(
  parameter int flitWidth = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  portVec               req,
  input  portVec               flitValid,
  input  logic [flitWidth-1:0] flitL,
  input  logic [flitWidth-1:0] flitN,
  input  logic [flitWidth-1:0] flitE,
  input  logic [flitWidth-1:0] flitW,
  input  logic [flitWidth-1:0] flitS,
  output portVec               grant,
  output logic [flitWidth-1:0] outFlit,
  output logic                 outValid
);

  // switch allocator for this output link
  outputArbiter #(.flitWidth(flitWidth)) arbiter (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitValid(flitValid),
    .flitL    (flitL),
    .flitN    (flitN),
    .flitE    (flitE),
    .flitW    (flitW),
    .flitS    (flitS),
    .grant    (grant)
  );

  // crossbar column, one cycle of latency
  flitMux #(.flitWidth(flitWidth)) mux (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .flitValid(flitValid),
    .flitL    (flitL),
    .flitN    (flitN),
    .flitE    (flitE),
    .flitW    (flitW),
    .flitS    (flitS),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: hw/flitMux.sv
`timescale 1ns/10ps

module flitMux
  import routerPkg::*;
#(
  parameter int flitWidth = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  portVec               grant,
  input  portVec               flitValid,
  input  logic [flitWidth-1:0] flitL,
  input  logic [flitWidth-1:0] flitN,
  input  logic [flitWidth-1:0] flitE,
  input  logic [flitWidth-1:0] flitW,
  input  logic [flitWidth-1:0] flitS,
  output logic [flitWidth-1:0] outFlit,
  output logic                 outValid
);

  logic [flitWidth-1:0] flitArr [numPorts];
  logic [flitWidth-1:0] selFlit;
  logic                 selValid;

  assign flitArr[portIdxL] = flitL;
  assign flitArr[portIdxN] = flitN;
  assign flitArr[portIdxE] = flitE;
  assign flitArr[portIdxW] = flitW;
  assign flitArr[portIdxS] = flitS;

  // grant is one-hot or zero
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < numPorts; p++)
      if (grant[p])
        selFlit = flitArr[p];
  end

  assign selValid = |(grant & flitValid); // ungranted strobes dropped

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    if (selValid)
      outFlit <= selFlit;
  end

endmodule

// File: hw/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter
  import routerPkg::*;
#(
  parameter int flitWidth = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  portVec               req,
  input  portVec               flitValid,
  input  logic [flitWidth-1:0] flitL,
  input  logic [flitWidth-1:0] flitN,
  input  logic [flitWidth-1:0] flitE,
  input  logic [flitWidth-1:0] flitW,
  input  logic [flitWidth-1:0] flitS,
  output portVec               grant
);

  arbState     state;
  arbState     nextState;
  portVec      runTimer;
  portVec      timesUp;
  int unsigned holder;

  // state that grants port p
  function automatic arbState stateOf(int unsigned p);
    return arbState'(6'b000010 << p);
  endfunction

  // first requester in rotation order, from start over span ports
  function automatic arbState pickNext(portVec r, int unsigned start, int unsigned span);
    arbState     s;
    int unsigned idx;
    s = arbIdle;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if (r[idx])
        s = stateOf(idx); // lower k wins
    end
    return s;
  endfunction

  // ############################
  // hold timers
  // ############################

  portTimer #(.flitWidth(flitWidth)) timerL (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitL),
    .flitValid(flitValid[portIdxL]),
    .runTimer (runTimer[portIdxL]),
    .timesUp  (timesUp[portIdxL])
  );

  portTimer #(.flitWidth(flitWidth)) timerN (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitN),
    .flitValid(flitValid[portIdxN]),
    .runTimer (runTimer[portIdxN]),
    .timesUp  (timesUp[portIdxN])
  );

  portTimer #(.flitWidth(flitWidth)) timerE (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitE),
    .flitValid(flitValid[portIdxE]),
    .runTimer (runTimer[portIdxE]),
    .timesUp  (timesUp[portIdxE])
  );

  portTimer #(.flitWidth(flitWidth)) timerW (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitW),
    .flitValid(flitValid[portIdxW]),
    .runTimer (runTimer[portIdxW]),
    .timesUp  (timesUp[portIdxW])
  );

  portTimer #(.flitWidth(flitWidth)) timerS (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitS),
    .flitValid(flitValid[portIdxS]),
    .runTimer (runTimer[portIdxS]),
    .timesUp  (timesUp[portIdxS])
  );

  // ############################
  // grant FSM
  // ############################

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
      grant[p] = (state == stateOf(p));
  end

  // index of the current holder
  always_comb
  begin
    holder = 0;
    for (int p = 0; p < numPorts; p++)
      if (grant[p])
        holder = p;
  end

  // only the holder that stays keeps its timer running
  assign runTimer = grant & req & ~timesUp;

  always_comb
  begin
    if (grant == '0)
      nextState = pickNext(req, portIdxL, numPorts); // fixed priority L..S
    else if (runTimer != '0)
      nextState = state;
    else
      nextState = pickNext(req, holder + 1, numPorts - 1); // skip holder
  end

endmodule

// File: hw/portTimer.sv
`timescale 1ns/10ps

module portTimer
  import routerPkg::*;
#(
  parameter int flitWidth = 16
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [flitWidth-1:0] flit,
  input  logic                 flitValid,
  input  logic                 runTimer,
  output logic                 timesUp
);

  flitId    id;
  pktLength headLen;
  pktLength holdLen; // limit from the last head flit
  pktLength count;

  // fields sit at the two ends of the word
  assign id      = flit[flitWidth-1 -: $bits(flitId)];
  assign headLen = flit[$bits(pktLength)-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
      count   <= '0;
    end
    else
    begin
      // captured on any head flit, granted or not
      if (flitValid && (id == flitIdHead))
        holdLen <= headLen;

      if (runTimer)
        count <= count + pktLength'(1);
      else
        count <= '0; // cleared whenever the port is not staying
    end
  end

  // high on the last cycle of the hold
  assign timesUp = (count == holdLen);

endmodule

// File: hw/routerPkg.sv
package routerPkg;

  // ############################
  // ports
  // ############################

  localparam int numPorts = 5;

  // bit positions in the port vectors
  localparam int portIdxL = 0;
  localparam int portIdxN = 1;
  localparam int portIdxE = 2;
  localparam int portIdxW = 3;
  localparam int portIdxS = 4;

  typedef logic [numPorts-1:0] portVec; // req, valid, grant

  // ############################
  // flit fields
  // ############################

  typedef logic [2:0]  flitId;    // top bits of a flit
  typedef logic [11:0] pktLength; // low bits of a head flit

  localparam flitId flitIdHead = 3'b001;

  // ############################
  // arbiter states, one-hot
  // ############################

  typedef enum logic [5:0] {
    arbIdle = 6'b000001,
    arbL    = 6'b000010,
    arbN    = 6'b000100,
    arbE    = 6'b001000,
    arbW    = 6'b010000,
    arbS    = 6'b100000
  } arbState;

endpackage
